// ==== hw/systolic_pkg.sv ====
//**************************************************************************
// Q8.8 element format, tile geometry and the tile word shared by all blocks
//**************************************************************************
`default_nettype none

package systolic_pkg;

    // Signed Q8.8 elements
    localparam int WIDTH      = 16;
    localparam int FRAC_WIDTH = 8;

    // Per element accumulator, wraps on overflow
    localparam int ACC_WIDTH  = 32;

    // Square tiles of BLOCK_SIZE x BLOCK_SIZE elements
    localparam int BLOCK_SIZE = 2;
    localparam int CHUNK_SIZE = BLOCK_SIZE * BLOCK_SIZE;

    typedef logic signed [WIDTH-1:0] elem_t;

    // One tile word, read either as flat lanes or as rows of columns.
    // Element (i, j) is lane i*BLOCK_SIZE + j
    typedef union packed {
        elem_t [CHUNK_SIZE-1:0]                 lane;
        elem_t [BLOCK_SIZE-1:0][BLOCK_SIZE-1:0] grid;
    } tile_t;

endpackage

`default_nettype wire

// ==== hw/input_skew.sv ====
//**************************************************************************
// Input skew stage, lane i of a tile is delayed by i cycles
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module input_skew #(
    parameter int STAGES = systolic_pkg::BLOCK_SIZE - 1
) (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire systolic_pkg::tile_t              in_vec,
    input  wire                                   in_valid,
    output systolic_pkg::tile_t                   out_vec,
    output logic [systolic_pkg::BLOCK_SIZE-1:0]   out_valid
);

    systolic_pkg::tile_t stage_q [STAGES];
    logic [STAGES-1:0]   valid_q;

    // Whole tile delay line, each lane taps its own depth
    always_ff @(posedge clk) begin
        stage_q[0] <= in_vec;
        for (int s = 1; s < STAGES; s++) begin
            stage_q[s] <= stage_q[s-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= in_valid;
            for (int s = 1; s < STAGES; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    // Lane 0 goes straight through
    always_comb begin
        out_vec.grid[0] = in_vec.grid[0];
        out_valid[0]    = in_valid;
        for (int i = 1; i < systolic_pkg::BLOCK_SIZE; i++) begin
            out_vec.grid[i] = stage_q[i-1].grid[i];
            out_valid[i]    = valid_q[i-1];
        end
    end

endmodule

`default_nettype wire

// ==== hw/mac_pe.sv ====
//**************************************************************************
// Processing element with operand forwarding and dot product accumulator
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module mac_pe (
    input  wire                                                     clk,
    input  wire                                                     rst_n,
    input  wire                                                     clear,
    input  wire                                                     valid_in,
    input  wire systolic_pkg::elem_t [systolic_pkg::BLOCK_SIZE-1:0] west_in,
    input  wire systolic_pkg::elem_t [systolic_pkg::BLOCK_SIZE-1:0] north_in,
    output systolic_pkg::elem_t [systolic_pkg::BLOCK_SIZE-1:0]      east_out,
    output systolic_pkg::elem_t [systolic_pkg::BLOCK_SIZE-1:0]      south_out,
    output logic                                                    valid_east,
    output logic                                                    valid_south,
    output logic signed [systolic_pkg::ACC_WIDTH-1:0]               acc
);

    logic signed [2*systolic_pkg::WIDTH-1:0]   prod;
    logic signed [systolic_pkg::ACC_WIDTH-1:0] term;
    logic signed [systolic_pkg::ACC_WIDTH-1:0] dot;

    // Full precision products, truncated back to Q8.8 before summing
    always_comb begin
        prod = '0;
        term = '0;
        dot  = '0;
        for (int k = 0; k < systolic_pkg::BLOCK_SIZE; k++) begin
            prod = $signed(west_in[k]) * $signed(north_in[k]);
            term = prod >>> systolic_pkg::FRAC_WIDTH;
            dot  = dot + term;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc         <= '0;
            valid_east  <= 1'b0;
            valid_south <= 1'b0;
        end else begin
            valid_east  <= valid_in;
            valid_south <= valid_in;
            // Clear wins over a same cycle accumulate
            if (clear) begin
                acc <= '0;
            end else if (valid_in) begin
                acc <= acc + dot;
            end
        end
    end

    // Operands move one hop per cycle
    always_ff @(posedge clk) begin
        east_out  <= west_in;
        south_out <= north_in;
    end

endmodule

`default_nettype wire

// ==== hw/systolic_array.sv ====
//**************************************************************************
// Grid of processing elements with saturation of the results to WIDTH
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module systolic_array (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   clear,
    input  wire systolic_pkg::tile_t              west_tile,
    input  wire [systolic_pkg::BLOCK_SIZE-1:0]    west_valid,
    input  wire systolic_pkg::tile_t              north_tile,
    input  wire [systolic_pkg::BLOCK_SIZE-1:0]    north_valid,
    output systolic_pkg::tile_t                   result
);

    localparam int BS      = systolic_pkg::BLOCK_SIZE;
    localparam int SAT_MAX = 2 ** (systolic_pkg::WIDTH - 1) - 1;
    localparam int SAT_MIN = -(2 ** (systolic_pkg::WIDTH - 1));

    // row_* runs east along row i, col_* runs south along column j
    systolic_pkg::elem_t [BS-1:0]             row_bus [BS][BS+1];
    systolic_pkg::elem_t [BS-1:0]             col_bus [BS+1][BS];
    logic                                     row_vld [BS][BS+1];
    logic                                     col_vld [BS+1][BS];
    logic signed [systolic_pkg::ACC_WIDTH-1:0] acc    [BS][BS];

    function automatic systolic_pkg::elem_t saturate(
        input logic signed [systolic_pkg::ACC_WIDTH-1:0] value
    );
        if (value > SAT_MAX) begin
            return systolic_pkg::elem_t'(SAT_MAX);
        end else if (value < SAT_MIN) begin
            return systolic_pkg::elem_t'(SAT_MIN);
        end
        return value[systolic_pkg::WIDTH-1:0];
    endfunction

    for (genvar i = 0; i < BS; i++) begin : g_edge
        assign row_bus[i][0] = west_tile.grid[i];
        assign row_vld[i][0] = west_valid[i];
        assign col_bus[0][i] = north_tile.grid[i];
        assign col_vld[0][i] = north_valid[i];
    end

    for (genvar i = 0; i < BS; i++) begin : g_row
        for (genvar j = 0; j < BS; j++) begin : g_col
            mac_pe mac_pe_i (
                .clk         (clk),
                .rst_n       (rst_n),
                .clear       (clear),
                .valid_in    (row_vld[i][j] & col_vld[i][j]),
                .west_in     (row_bus[i][j]),
                .north_in    (col_bus[i][j]),
                .east_out    (row_bus[i][j+1]),
                .south_out   (col_bus[i+1][j]),
                .valid_east  (row_vld[i][j+1]),
                .valid_south (col_vld[i+1][j]),
                .acc         (acc[i][j])
            );
        end
    end

    always_comb begin
        for (int i = 0; i < BS; i++) begin
            for (int j = 0; j < BS; j++) begin
                result.grid[i][j] = saturate(acc[i][j]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/tile_core.sv ====
//**************************************************************************
// One systolic core with beat counting, job end flags, skews and the array
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module tile_core #(
    parameter int INNER_DIMENSION = 64
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       en,
    input  wire                       reset_acc,
    input  wire systolic_pkg::tile_t  input_w,
    input  wire systolic_pkg::tile_t  input_n,
    output logic                      systolic_finish,
    output logic                      accumulator_done,
    output systolic_pkg::tile_t       out
);

    localparam int BS        = systolic_pkg::BLOCK_SIZE;
    localparam int NUM_BEATS = INNER_DIMENSION / BS;
    // Last element (BS-1, BS-1) adds 2*(BS-1) cycles after acceptance
    localparam int DRAIN     = 2 * (BS - 1) + 1;
    localparam int BEAT_W    = $clog2(NUM_BEATS + 1);
    localparam int DRAIN_W   = $clog2(DRAIN + 1);

    logic                accept;
    logic [BEAT_W-1:0]   beat_cnt;
    logic [DRAIN_W-1:0]  drain_cnt;
    systolic_pkg::tile_t n_cols;
    systolic_pkg::tile_t west_skewed;
    systolic_pkg::tile_t north_skewed;
    logic [BS-1:0]       west_valid;
    logic [BS-1:0]       north_valid;

    assign accept = en & ~reset_acc & ~systolic_finish;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt        <= '0;
            systolic_finish <= 1'b0;
        end else if (reset_acc) begin
            beat_cnt        <= '0;
            systolic_finish <= 1'b0;
        end else if (accept) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == BEAT_W'(NUM_BEATS - 1)) begin
                systolic_finish <= 1'b1;
            end
        end
    end

    // Wait for the last beat to reach the far corner
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drain_cnt        <= '0;
            accumulator_done <= 1'b0;
        end else if (reset_acc) begin
            drain_cnt        <= '0;
            accumulator_done <= 1'b0;
        end else if (systolic_finish && !accumulator_done) begin
            if (drain_cnt == DRAIN_W'(DRAIN - 1)) begin
                accumulator_done <= 1'b1;
            end else begin
                drain_cnt <= drain_cnt + 1'b1;
            end
        end
    end

    // B columns as lanes for the north skew
    always_comb begin
        for (int r = 0; r < BS; r++) begin
            for (int c = 0; c < BS; c++) begin
                n_cols.grid[c][r] = input_n.grid[r][c];
            end
        end
    end

    input_skew #(.STAGES(BS - 1)) west_skew_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_vec    (input_w),
        .in_valid  (accept),
        .out_vec   (west_skewed),
        .out_valid (west_valid)
    );

    input_skew #(.STAGES(BS - 1)) north_skew_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_vec    (n_cols),
        .in_valid  (accept),
        .out_vec   (north_skewed),
        .out_valid (north_valid)
    );

    systolic_array systolic_array_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (reset_acc),
        .west_tile   (west_skewed),
        .west_valid  (west_valid),
        .north_tile  (north_skewed),
        .north_valid (north_valid),
        .result      (out)
    );

endmodule

`default_nettype wire

// ==== hw/result_buffer.sv ====
//**************************************************************************
// Result buffer, captures all core tiles and shifts them out one per cycle
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module result_buffer #(
    parameter int NUM_CORES = 4
) (
    input  wire                                             clk,
    input  wire                                             rst_n,
    input  wire                                             start,
    input  wire [NUM_CORES*$bits(systolic_pkg::tile_t)-1:0] in,
    output logic                                            out_valid,
    output systolic_pkg::tile_t                             output_buffer
);

    localparam int LANES = systolic_pkg::CHUNK_SIZE;
    localparam int W     = systolic_pkg::WIDTH;
    localparam int CNT_W = $clog2(NUM_CORES + 1);

    logic                start_q;
    logic                load;
    logic [CNT_W-1:0]    count;
    systolic_pkg::tile_t shift_q [NUM_CORES];

    // Capture on the first cycle start is seen high
    assign load = start & ~start_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q <= 1'b0;
            count   <= '0;
        end else begin
            start_q <= start;
            if (load) begin
                count <= CNT_W'(NUM_CORES);
            end else if (count != '0) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            for (int c = 0; c < NUM_CORES; c++) begin
                for (int k = 0; k < LANES; k++) begin
                    shift_q[c].lane[k] <= in[(c*LANES + k)*W +: W];
                end
            end
        end else if (count != '0) begin
            // Core 0 leaves first
            for (int c = 0; c < NUM_CORES - 1; c++) begin
                shift_q[c] <= shift_q[c+1];
            end
        end
    end

    assign out_valid     = (count != '0);
    assign output_buffer = shift_q[0];

endmodule

`default_nettype wire

// ==== hw/matrix_engine.sv ====
//**************************************************************************
// Matrix engine top, parallel tile cores and the shared result buffer
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module matrix_engine #(
    parameter int INNER_DIMENSION = 64,
    parameter int NUM_CORES       = 4
) (
    input  wire                                                        clk,
    input  wire                                                        rst_n,
    input  wire                                                        en,
    input  wire                                                        reset_acc,
    input  wire systolic_pkg::tile_t                                   input_n,
    input  wire [NUM_CORES*systolic_pkg::CHUNK_SIZE*systolic_pkg::WIDTH-1:0] input_w,
    output logic                                                       systolic_finish,
    output logic                                                       accumulator_done,
    output logic                                                       out_valid,
    output systolic_pkg::tile_t                                        out_top
);

    localparam int TILE_BITS = $bits(systolic_pkg::tile_t);
    localparam int LANES     = systolic_pkg::CHUNK_SIZE;
    localparam int W         = systolic_pkg::WIDTH;

    systolic_pkg::tile_t          core_w [NUM_CORES];
    wire [NUM_CORES-1:0]           finish_vec;
    wire [NUM_CORES-1:0]           done_vec;
    wire [NUM_CORES*TILE_BITS-1:0] core_out;

    // Core c takes slice c of the west input
    always_comb begin
        for (int c = 0; c < NUM_CORES; c++) begin
            for (int k = 0; k < LANES; k++) begin
                core_w[c].lane[k] = input_w[(c*LANES + k)*W +: W];
            end
        end
    end

    for (genvar c = 0; c < NUM_CORES; c++) begin : g_core
        tile_core #(.INNER_DIMENSION(INNER_DIMENSION)) tile_core_i (
            .clk              (clk),
            .rst_n            (rst_n),
            .en               (en),
            .reset_acc        (reset_acc),
            .input_w          (core_w[c]),
            .input_n          (input_n),
            .systolic_finish  (finish_vec[c]),
            .accumulator_done (done_vec[c]),
            .out              (core_out[c*TILE_BITS +: TILE_BITS])
        );
    end

    // Cores run in lockstep
    assign systolic_finish  = &finish_vec;
    assign accumulator_done = &done_vec;

    result_buffer #(.NUM_CORES(NUM_CORES)) result_buffer_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (accumulator_done),
        .in            (core_out),
        .out_valid     (out_valid),
        .output_buffer (out_top)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
//**************************************************************************
// Free running testbench clock
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== tb/matrix_engine_assertions.sv ====
//**************************************************************************
// Protocol assertions on the matrix engine flags, bound to the top level
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module matrix_engine_assertions (
    input wire clk,
    input wire rst_n,
    input wire en,
    input wire reset_acc,
    input wire systolic_finish,
    input wire accumulator_done,
    input wire out_valid
);

    int violations = 0;

    a_valid_needs_done: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> accumulator_done
    ) else begin
        $error("out_valid is high while accumulator_done is low");
        violations++;
    end

    a_no_en_with_clear: assert property (
        @(posedge clk) disable iff (!rst_n) !(en && reset_acc)
    ) else begin
        $error("en and reset_acc are high together");
        violations++;
    end

    a_done_needs_finish: assert property (
        @(posedge clk) disable iff (!rst_n) accumulator_done |-> systolic_finish
    ) else begin
        $error("accumulator_done is high while systolic_finish is low");
        violations++;
    end

    // Sampled mid cycle, after the first rising edge has applied reset
    a_flags_low_in_reset: assert property (
        @(negedge clk) !rst_n |-> !(systolic_finish || accumulator_done || out_valid)
    ) else begin
        $error("a status flag is high during reset");
        violations++;
    end

endmodule

bind matrix_engine matrix_engine_assertions assertions_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .en               (en),
    .reset_acc        (reset_acc),
    .systolic_finish  (systolic_finish),
    .accumulator_done (accumulator_done),
    .out_valid        (out_valid)
);

`default_nettype wire

// ==== tb/matrix_engine_tb.sv ====
//**************************************************************************
// Matrix engine testbench, stimulus, reference model and result checker
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module matrix_engine_tb;

    localparam int NUM_CORES       = 2;
    localparam int INNER_DIMENSION = 8;
    localparam int NUM_BEATS       = INNER_DIMENSION / systolic_pkg::BLOCK_SIZE;
    localparam int BS              = systolic_pkg::BLOCK_SIZE;
    localparam int WAIT_LIMIT      = 64;
    localparam int W_BITS          = NUM_CORES * $bits(systolic_pkg::tile_t);

    wire                 clk;
    logic                rst_n;
    logic                en;
    logic                reset_acc;
    systolic_pkg::tile_t input_n;
    logic [W_BITS-1:0]   input_w;
    logic                systolic_finish;
    logic                accumulator_done;
    logic                out_valid;
    systolic_pkg::tile_t out_top;

    integer              seed = 17;
    int                  valid_run;
    systolic_pkg::tile_t a_job [NUM_BEATS][NUM_CORES];
    systolic_pkg::tile_t b_job [NUM_BEATS];
    systolic_pkg::tile_t exp_q [$];

    tb_clock #(.PERIOD(40)) tb_clock_i (.clk(clk));

    matrix_engine #(
        .INNER_DIMENSION (INNER_DIMENSION),
        .NUM_CORES       (NUM_CORES)
    ) matrix_engine_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .en               (en),
        .reset_acc        (reset_acc),
        .input_n          (input_n),
        .input_w          (input_w),
        .systolic_finish  (systolic_finish),
        .accumulator_done (accumulator_done),
        .out_valid        (out_valid),
        .out_top          (out_top)
    );

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        assert (actual === expected) else begin
            stop_with_failure($sformatf("ERROR t=%0t %s expected %b got %b",
                $time, name, expected, actual));
        end
    endtask

    function automatic logic flag_value(input int which);
        case (which)
            0: return systolic_finish;
            1: return accumulator_done;
            default: return out_valid;
        endcase
    endfunction

    task automatic wait_for_level(input int which, input logic level, input string name);
        int cycles;
        cycles = 0;
        while (flag_value(which) !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_failure({"Timed out waiting for ", name});
            end
        end
    endtask

    function automatic systolic_pkg::tile_t random_tile(input int span);
        systolic_pkg::tile_t t;
        for (int k = 0; k < systolic_pkg::CHUNK_SIZE; k++) begin
            t.lane[k] = systolic_pkg::elem_t'($random(seed) % span);
        end
        return t;
    endfunction

    // Magnitudes from 64.0 up to just under 128.0
    function automatic systolic_pkg::tile_t big_tile(input bit negative);
        systolic_pkg::tile_t t;
        int mag;
        for (int k = 0; k < systolic_pkg::CHUNK_SIZE; k++) begin
            mag = 32'h4000 + ($random(seed) & 32'h3fff);
            t.lane[k] = systolic_pkg::elem_t'(negative ? -mag : mag);
        end
        return t;
    endfunction

    task automatic fill_operands(input bit saturate);
        for (int b = 0; b < NUM_BEATS; b++) begin
            b_job[b] = saturate ? big_tile(1'b0) : random_tile(1024);
            for (int c = 0; c < NUM_CORES; c++) begin
                a_job[b][c] = saturate ? big_tile(c != 0) : random_tile(1024);
            end
        end
    endtask

    function automatic logic [W_BITS-1:0] pack_west(input int b);
        logic [W_BITS-1:0] w;
        for (int c = 0; c < NUM_CORES; c++) begin
            w[c*$bits(systolic_pkg::tile_t) +: $bits(systolic_pkg::tile_t)] = a_job[b][c];
        end
        return w;
    endfunction

    // Truncated Q8.8 products, wrapped sum, saturated result
    function automatic systolic_pkg::tile_t ref_tile(input int core);
        systolic_pkg::tile_t res;
        logic signed [systolic_pkg::ACC_WIDTH-1:0] sum;
        logic signed [2*systolic_pkg::WIDTH-1:0]   prod;
        for (int i = 0; i < BS; i++) begin
            for (int j = 0; j < BS; j++) begin
                sum = '0;
                for (int b = 0; b < NUM_BEATS; b++) begin
                    for (int k = 0; k < BS; k++) begin
                        prod = $signed(a_job[b][core].grid[i][k]) * $signed(b_job[b].grid[k][j]);
                        sum  = sum + (prod >>> systolic_pkg::FRAC_WIDTH);
                    end
                end
                if (sum > 32767) begin
                    res.grid[i][j] = 16'sh7fff;
                end else if (sum < -32768) begin
                    res.grid[i][j] = 16'sh8000;
                end else begin
                    res.grid[i][j] = sum[systolic_pkg::WIDTH-1:0];
                end
            end
        end
        return res;
    endfunction

    task automatic clear_job();
        @(posedge clk);
        reset_acc <= 1'b1;
        @(posedge clk);
        reset_acc <= 1'b0;
        @(negedge clk);
        check_bit("systolic_finish", systolic_finish, 1'b0);
        check_bit("accumulator_done", accumulator_done, 1'b0);
    endtask

    // One job, optionally with idle gaps or ignored beats after finish
    task automatic run_job(input bit gaps, input int extra);
        int idle;
        valid_run = 0;
        for (int c = 0; c < NUM_CORES; c++) begin
            exp_q.push_back(ref_tile(c));
        end
        for (int b = 0; b < NUM_BEATS; b++) begin
            @(posedge clk);
            en      <= 1'b1;
            input_w <= pack_west(b);
            input_n <= b_job[b];
            if (gaps && b < NUM_BEATS - 1) begin
                idle = 1 + ($unsigned($random(seed)) % 3);
                repeat (idle) begin
                    @(posedge clk);
                    en <= 1'b0;
                end
                @(negedge clk);
                check_bit("systolic_finish", systolic_finish, 1'b0);
            end
        end
        @(posedge clk);
        for (int e = 0; e < extra; e++) begin
            input_w <= {random_tile(1024), random_tile(1024)};
            input_n <= random_tile(1024);
            @(posedge clk);
        end
        en <= 1'b0;
        @(negedge clk);
        check_bit("systolic_finish", systolic_finish, 1'b1);
        wait_for_level(1, 1'b1, "accumulator_done");
        wait_for_level(2, 1'b1, "out_valid to rise");
        wait_for_level(2, 1'b0, "out_valid to fall");
        repeat (2) @(negedge clk);
        assert (valid_run == NUM_CORES) else begin
            stop_with_failure($sformatf("ERROR t=%0t out_valid cycles expected %0d got %0d",
                $time, NUM_CORES, valid_run));
        end
    endtask

    always @(negedge clk) begin : compare_outputs
        systolic_pkg::tile_t expected;
        if (matrix_engine_i.assertions_i.violations != 0) begin
            stop_with_failure("A protocol assertion on the DUT failed");
        end
        if (rst_n && out_valid) begin
            assert (exp_q.size() > 0) else begin
                stop_with_failure("The DUT streamed a tile when none was expected");
            end
            expected = exp_q.pop_front();
            valid_run++;
            assert (out_top === expected) else begin
                stop_with_failure($sformatf("ERROR t=%0t out_top expected %h got %h",
                    $time, expected, out_top));
            end
        end
    end

    initial begin
        rst_n     = 1'b0;
        en        = 1'b0;
        reset_acc = 1'b0;
        input_n   = '0;
        input_w   = '0;
        valid_run = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(negedge clk);
        check_bit("systolic_finish", systolic_finish, 1'b0);
        check_bit("accumulator_done", accumulator_done, 1'b0);
        check_bit("out_valid", out_valid, 1'b0);

        fill_operands(1'b0);
        run_job(1'b0, 0);
        // Same operands again, spread out in time
        clear_job();
        run_job(1'b1, 0);
        clear_job();
        fill_operands(1'b1);
        run_job(1'b0, 0);
        clear_job();
        fill_operands(1'b0);
        run_job(1'b0, 0);
        clear_job();
        fill_operands(1'b0);
        run_job(1'b0, 2);

        if (matrix_engine_i.assertions_i.violations == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_with_failure("A protocol assertion on the DUT failed");
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/systolic_pkg.sv
hw/input_skew.sv
hw/mac_pe.sv
hw/systolic_array.sv
hw/tile_core.sv
hw/result_buffer.sv
hw/matrix_engine.sv
tb/tb_clock.sv
tb/matrix_engine_assertions.sv
tb/matrix_engine_tb.sv
